//--- source/exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 32;
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW = $clog2(DMEM_WORDS);
  localparam int MEM_LAT = 2;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC = 12'h305;
  localparam logic [11:0] CSR_MEPC = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;

  localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 32'd11; // environment call from M-mode

  typedef enum logic [3:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_CSR,
    OP_ECALL,
    OP_MRET,
    OP_EBREAK
  } op_class_e;

  // SGE and SGEU give 1 when src1 >= src2
  typedef enum logic [3:0] {
    ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU, SGE, SGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  typedef struct packed {
    op_class_e op_class;
    alu_op_e alu_op;
    csr_op_e csr_op;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    logic [4:0] rd;
    logic [11:0] csr_addr;
  } uop_t;

  typedef struct packed {
    logic [4:0] rd;
    logic rd_wen;
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] npc;
    logic trap;
    logic ebreak;
  } result_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic we;
  } mem_req_t;

endpackage

//--- source/exu_skid_buf.sv
`timescale 1ns/1ps

module exu_skid_buf #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic main_valid, skid_valid;
  T main_data, skid_data;
  logic in_fire;

  assign in_ready_o = !skid_valid; // registered, so no ready chain back upstream
  assign in_fire = in_valid_i && in_ready_o;
  assign out_valid_o = main_valid;
  assign out_data_o = main_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (!main_valid || out_ready_i) begin
      main_valid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1; // main is stalled so park the new item
    end
  end

  always_ff @(posedge clk) begin
    if (!main_valid || out_ready_i) begin
      main_data <= skid_valid ? skid_data : in_data_i;
    end else if (in_fire) begin
      skid_data <= in_data_i;
    end
  end

  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- source/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic lt_s, lt_u;

  assign shamt = src2_i[4:0];
  assign lt_s = $signed(src1_i) < $signed(src2_i);
  assign lt_u = src1_i < src2_i;

  always_comb begin
    case (alu_op_i)
      ADD:  res_o = src1_i + src2_i;
      SUB:  res_o = src1_i - src2_i;
      XOR:  res_o = src1_i ^ src2_i;
      OR:   res_o = src1_i | src2_i;
      AND:  res_o = src1_i & src2_i;
      SLL:  res_o = src1_i << shamt;
      SRL:  res_o = src1_i >> shamt;
      SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      // comparisons return a single bit, zero extended
      SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      SGE:  res_o = {{(XLEN-1){1'b0}}, !lt_s};
      SGEU: res_o = {{(XLEN-1){1'b0}}, !lt_u};
      default: res_o = '0;
    endcase
  end

endmodule

//--- source/exu_branch.sv
`timescale 1ns/1ps

module exu_branch import exu_pkg::*; (
  input  uop_t            uop_i,
  input  logic [XLEN-1:0] alu_res_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  output logic [XLEN-1:0] npc_o
);

  logic taken;
  logic [XLEN-1:0] seq_pc;

  assign seq_pc = uop_i.pc + XLEN'(4);

  always_comb begin
    case (uop_i.alu_op)
      SUB: taken = (alu_res_i == '0); // beq style, equal gives zero difference
      XOR, SLT, SLTU, SGE, SGEU: taken = |alu_res_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (uop_i.op_class)
      OP_BRANCH: npc_o = taken ? uop_i.pc + uop_i.imm : seq_pc;
      OP_JAL:    npc_o = uop_i.pc + uop_i.imm;
      OP_JALR:   npc_o = uop_i.src1 + uop_i.imm;
      OP_ECALL:  npc_o = mtvec_i;
      OP_MRET:   npc_o = mepc_i;
      default:   npc_o = seq_pc;
    endcase
  end

endmodule

//--- source/exu_csr_file.sv
`timescale 1ns/1ps

module exu_csr_file import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            commit_i,
  input  op_class_e       op_class_i,
  input  csr_op_e         csr_op_i,
  input  logic [11:0]     addr_i,
  input  logic [XLEN-1:0] src_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus, mtvec, mepc, mcause;
  logic [XLEN-1:0] wdata;

  assign mtvec_o = mtvec;
  assign mepc_o = mepc;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MTVEC:   rdata_o = mtvec;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      default:     rdata_o = '0; // unimplemented CSRs read as zero
    endcase
  end

  always_comb begin
    case (csr_op_i)
      CSR_RW:  wdata = src_i;
      CSR_RS:  wdata = rdata_o | src_i;
      CSR_RC:  wdata = rdata_o & ~src_i;
      default: wdata = rdata_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (commit_i) begin
      case (op_class_i)
        OP_CSR: begin
          case (addr_i)
            CSR_MSTATUS: mstatus <= wdata;
            CSR_MTVEC:   mtvec <= wdata;
            CSR_MEPC:    mepc <= wdata;
            CSR_MCAUSE:  mcause <= wdata;
            default: ;
          endcase
        end
        OP_ECALL: begin
          mepc <= pc_i;
          mcause <= MCAUSE_ECALL_M;
        end
        OP_MRET: begin
          mstatus[3] <= mstatus[7]; // MIE restored from MPIE
          mstatus[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  a_commit_class: assert property (@(posedge clk) disable iff (rst)
    commit_i |-> op_class_i inside {OP_CSR, OP_ECALL, OP_MRET});

endmodule

//--- source/exu_lsu.sv
`timescale 1ns/1ps

module exu_lsu import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid_i,
  input  mem_req_t        req_i,
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_rdata_o
);

  logic [XLEN-1:0] mem [DMEM_WORDS];
  logic [MEM_LAT-1:0] vld_sr;
  logic [XLEN-1:0] rdata_q;
  logic [DMEM_AW-1:0] idx;

  assign idx = req_i.addr[DMEM_AW+1:2]; // word index, byte offset dropped
  assign rsp_valid_o = vld_sr[MEM_LAT-1];
  assign rsp_rdata_o = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      mem[idx] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[MEM_LAT-2:0], req_valid_i};
    end
  end

  // only one request is in flight, so a single data register is enough
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      rdata_q <= req_i.we ? '0 : mem[idx];
    end
  end

  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> vld_sr == '0);

endmodule

//--- source/exu_core.sv
`timescale 1ns/1ps

module exu_core import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            uop_valid_i,
  output logic            uop_ready_o,
  input  uop_t            uop_i,
  output logic            res_valid_o,
  input  logic            res_ready_i,
  output result_t         res_o,
  output logic            mem_req_valid_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_rsp_valid_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    HOLD
  } state_e;

  state_e state;
  uop_t uop_q;
  logic [XLEN-1:0] ldata_q;
  logic req_sent;
  logic accept, res_fire, csr_commit, acc_mem;
  logic [XLEN-1:0] alu_res, npc, csr_rdata, mtvec, mepc;

  assign uop_ready_o = (state == IDLE);
  assign accept = uop_valid_i && uop_ready_o;
  assign acc_mem = uop_i.op_class inside {OP_LOAD, OP_STORE};
  assign res_valid_o = (state == HOLD);
  assign res_fire = res_valid_o && res_ready_i;

  // CSR state changes on the same edge the result leaves
  assign csr_commit = res_fire && (uop_q.op_class inside {OP_CSR, OP_ECALL, OP_MRET});

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      req_sent <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          req_sent <= 1'b0;
          if (accept) begin
            state <= acc_mem ? MEM_WAIT : HOLD;
          end
        end
        MEM_WAIT: begin
          req_sent <= 1'b1; // request goes out on the first cycle only
          if (mem_rsp_valid_i) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (res_ready_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      uop_q <= uop_i;
    end
    if (state == MEM_WAIT && mem_rsp_valid_i) begin
      ldata_q <= mem_rdata_i;
    end
  end

  assign mem_req_valid_o = (state == MEM_WAIT) && !req_sent;
  assign mem_req_o.addr = uop_q.src1 + uop_q.imm;
  assign mem_req_o.wdata = uop_q.src2;
  assign mem_req_o.we = (uop_q.op_class == OP_STORE);

  exu_alu alu_i (
    .alu_op_i (uop_q.alu_op),
    .src1_i   (uop_q.src1),
    .src2_i   (uop_q.src2),
    .res_o    (alu_res)
  );

  exu_branch branch_i (
    .uop_i     (uop_q),
    .alu_res_i (alu_res),
    .mtvec_i   (mtvec),
    .mepc_i    (mepc),
    .npc_o     (npc)
  );

  exu_csr_file csr_i (
    .clk        (clk),
    .rst        (rst),
    .commit_i   (csr_commit),
    .op_class_i (uop_q.op_class),
    .csr_op_i   (uop_q.csr_op),
    .addr_i     (uop_q.csr_addr),
    .src_i      (uop_q.src1),
    .pc_i       (uop_q.pc),
    .rdata_o    (csr_rdata),
    .mtvec_o    (mtvec),
    .mepc_o     (mepc)
  );

  always_comb begin
    res_o = '0;
    res_o.rd = uop_q.rd;
    res_o.npc = npc;
    case (uop_q.op_class)
      OP_ALU: begin
        res_o.rd_wen = 1'b1;
        res_o.rd_wdata = alu_res;
      end
      OP_JAL, OP_JALR: begin
        res_o.rd_wen = 1'b1;
        res_o.rd_wdata = uop_q.pc + XLEN'(4); // link address
      end
      OP_LOAD: begin
        res_o.rd_wen = 1'b1;
        res_o.rd_wdata = ldata_q;
      end
      OP_CSR: begin
        res_o.rd_wen = 1'b1;
        res_o.rd_wdata = csr_rdata;
      end
      OP_ECALL: res_o.trap = 1'b1;
      OP_EBREAK: res_o.ebreak = 1'b1;
      default: ;
    endcase
  end

  a_req_mem_only: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req_valid_o) |-> uop_q.op_class inside {OP_LOAD, OP_STORE});

endmodule

//--- source/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    uop_valid_i,
  output logic    uop_ready_o,
  input  uop_t    uop_i,
  output logic    res_valid_o,
  input  logic    res_ready_i,
  output result_t res_o
);

  logic core_uop_valid, core_uop_ready;
  uop_t core_uop;
  logic core_res_valid, core_res_ready;
  result_t core_res;
  logic mem_req_valid, mem_rsp_valid;
  mem_req_t mem_req;
  logic [XLEN-1:0] mem_rdata;

  exu_skid_buf #(.T(uop_t)) in_buf_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (uop_valid_i),
    .in_ready_o  (uop_ready_o),
    .in_data_i   (uop_i),
    .out_valid_o (core_uop_valid),
    .out_ready_i (core_uop_ready),
    .out_data_o  (core_uop)
  );

  exu_core core_i (
    .clk             (clk),
    .rst             (rst),
    .uop_valid_i     (core_uop_valid),
    .uop_ready_o     (core_uop_ready),
    .uop_i           (core_uop),
    .res_valid_o     (core_res_valid),
    .res_ready_i     (core_res_ready),
    .res_o           (core_res),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rdata_i     (mem_rdata)
  );

  exu_lsu lsu_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_rdata_o (mem_rdata)
  );

  exu_skid_buf #(.T(result_t)) out_buf_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (core_res_valid),
    .in_ready_o  (core_res_ready),
    .in_data_i   (core_res),
    .out_valid_o (res_valid_o),
    .out_ready_i (res_ready_i),
    .out_data_o  (res_o)
  );

endmodule

//--- dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int WAIT_CYCLES = 40; // generous per-vector budget for the watchdog
  localparam int DRAIN_CYCLES = 20;
  localparam string STIM_FILE = "dv/exu_stim.txt";

  logic clk;
  logic rst;
  logic uop_valid;
  logic uop_ready;
  uop_t uop;
  logic res_valid;
  logic res_ready;
  result_t res;

  uop_t vec_q[$];
  result_t want_q[$];
  int n_vec = 0;
  int n_res = 0;
  int n_chk = 0;
  int n_err = 0;
  int n_setup_err = 0;
  bit loaded = 1'b0;

  exu_top exu_top_i (
    .clk         (clk),
    .rst         (rst),
    .uop_valid_i (uop_valid),
    .uop_ready_o (uop_ready),
    .uop_i       (uop),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_o       (res)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] want);
    n_chk++;
    if (got !== want) begin
      n_err++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic compare_result(input result_t want);
    check_val("rd", XLEN'(res.rd), XLEN'(want.rd));
    check_val("rd_wen", XLEN'(res.rd_wen), XLEN'(want.rd_wen));
    if (want.rd_wen) begin
      check_val("rd_wdata", res.rd_wdata, want.rd_wdata); // don't care without a write
    end
    check_val("npc", res.npc, want.npc);
    check_val("trap", XLEN'(res.trap), XLEN'(want.trap));
    check_val("ebreak", XLEN'(res.ebreak), XLEN'(want.ebreak));
  endtask

  // each data line holds the uop fields and then the expected result fields
  task automatic load_vectors();
    int fd;
    int code;
    string line;
    logic [XLEN-1:0] f [15];
    uop_t u;
    result_t r;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      n_setup_err++;
      $display("could not open the stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                         f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
          if (code == 15) begin
            u.op_class = op_class_e'(f[0][3:0]);
            u.alu_op = alu_op_e'(f[1][3:0]);
            u.csr_op = csr_op_e'(f[2][1:0]);
            u.pc = f[3];
            u.src1 = f[4];
            u.src2 = f[5];
            u.imm = f[6];
            u.rd = f[7][4:0];
            u.csr_addr = f[8][11:0];
            r.rd = f[9][4:0];
            r.rd_wen = f[10][0];
            r.rd_wdata = f[11];
            r.npc = f[12];
            r.trap = f[13][0];
            r.ebreak = f[14][0];
            vec_q.push_back(u);
            want_q.push_back(r);
          end else begin
            n_setup_err++;
            $display("stimulus line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one vector per transfer with idle gaps of 0 to 3 cycles
  task automatic drive_all();
    int gap;
    foreach (vec_q[i]) begin
      gap = $urandom_range(3);
      if (gap > 0) begin
        uop_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      uop_valid <= 1'b1;
      uop <= vec_q[i];
      @(posedge clk);
      while (!uop_ready) @(posedge clk);
    end
    uop_valid <= 1'b0;
  endtask

  task automatic toggle_ready();
    forever begin
      @(posedge clk);
      res_ready <= ($urandom_range(9) < 7); // ready about 70 percent of the time
    end
  endtask

  always @(posedge clk) begin
    if (!rst && res_valid && res_ready) begin
      n_res++;
      if (want_q.size() == 0) begin
        n_err++;
        $display("result %0d came out with no vector left to match it", n_res);
      end else begin
        compare_result(want_q.pop_front());
      end
    end
  end

  initial begin
    wait (loaded);
    #((n_vec * WAIT_CYCLES + RST_CYCLES + DRAIN_CYCLES) * CLK_PERIOD);
    $display("timeout: only %0d of %0d results arrived", n_res, n_vec);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(43));
    clk = 1'b0;
    rst = 1'b1;
    uop_valid = 1'b0;
    uop = '0;
    res_ready = 1'b0;
    fork
      toggle_ready();
    join_none
    load_vectors();
    n_vec = vec_q.size();
    if (n_vec == 0) begin
      n_setup_err++;
      $display("the stimulus file holds no vectors");
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    check_val("uop_ready_o", XLEN'(uop_ready), XLEN'(1'b1));
    check_val("res_valid_o", XLEN'(res_valid), XLEN'(1'b0));
    rst <= 1'b0;
    drive_all();
    wait (n_res == n_vec);
    repeat (DRAIN_CYCLES) @(posedge clk); // catch any extra result
    $display("results %0d of %0d, checks %0d, errors %0d", n_res, n_vec, n_chk,
             n_err + n_setup_err);
    if (n_err == 0 && n_setup_err == 0 && n_res == n_vec) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- dv/exu_stim.txt
# uop: op_class alu_op csr_op pc src1 src2 imm rd csr_addr
# expected: rd rd_wen rd_wdata npc trap ebreak
0 0 0 00000100 00000005 00000007 00000000 01 000 01 1 0000000c 00000104 0 0
0 1 0 00000104 00000003 00000005 00000000 02 000 02 1 fffffffe 00000108 0 0
0 2 0 00000108 f0f0f0f0 ff00ff00 00000000 03 000 03 1 0ff00ff0 0000010c 0 0
0 3 0 0000010c 12340000 00005678 00000000 04 000 04 1 12345678 00000110 0 0
0 4 0 00000110 ffff0000 12345678 00000000 05 000 05 1 12340000 00000114 0 0
0 5 0 00000114 00000001 00000024 00000000 06 000 06 1 00000010 00000118 0 0
0 6 0 00000118 80000000 00000004 00000000 07 000 07 1 08000000 0000011c 0 0
0 7 0 0000011c 80000000 00000004 00000000 08 000 08 1 f8000000 00000120 0 0
0 8 0 00000120 ffffffff 00000001 00000000 09 000 09 1 00000001 00000124 0 0
0 9 0 00000124 ffffffff 00000001 00000000 0a 000 0a 1 00000000 00000128 0 0
0 a 0 00000128 ffffffff 00000001 00000000 0b 000 0b 1 00000000 0000012c 0 0
0 b 0 0000012c ffffffff 00000001 00000000 0c 000 0c 1 00000001 00000130 0 0
1 1 0 00000130 00000007 00000007 00000040 00 000 00 0 00000000 00000170 0 0
1 1 0 00000134 00000007 00000008 00000040 00 000 00 0 00000000 00000138 0 0
1 2 0 00000138 00000001 00000002 00000040 00 000 00 0 00000000 00000178 0 0
1 8 0 0000013c ffffffff 00000001 00000040 00 000 00 0 00000000 0000017c 0 0
1 9 0 00000140 ffffffff 00000001 00000040 00 000 00 0 00000000 00000144 0 0
1 a 0 00000144 00000005 00000005 00000040 00 000 00 0 00000000 00000184 0 0
1 b 0 00000148 00000001 ffffffff 00000040 00 000 00 0 00000000 0000014c 0 0
2 0 0 0000014c 00000000 00000000 fffffff4 01 000 01 1 00000150 00000140 0 0
3 0 0 00000150 00001000 00000000 00000010 02 000 02 1 00000154 00001010 0 0
5 0 0 00000154 00000020 deadbeef 00000008 00 000 00 0 00000000 00000158 0 0
4 0 0 00000158 00000020 00000000 00000008 03 000 03 1 deadbeef 0000015c 0 0
4 0 0 0000015c 00000040 00000000 00000004 04 000 04 1 00000000 00000160 0 0
6 0 0 00000160 00000200 00000000 00000000 05 305 05 1 00000000 00000164 0 0
6 0 1 00000164 00000003 00000000 00000000 06 305 06 1 00000200 00000168 0 0
6 0 2 00000168 00000001 00000000 00000000 07 305 07 1 00000203 0000016c 0 0
6 0 1 0000016c 00000000 00000000 00000000 08 305 08 1 00000202 00000170 0 0
6 0 0 00000170 00000400 00000000 00000000 09 341 09 1 00000000 00000174 0 0
6 0 2 00000174 00000000 00000000 00000000 0a 341 0a 1 00000400 00000178 0 0
6 0 0 00000178 12345678 00000000 00000000 0b 340 0b 1 00000000 0000017c 0 0
6 0 1 0000017c 00000000 00000000 00000000 0c 340 0c 1 00000000 00000180 0 0
7 0 0 00000180 00000000 00000000 00000000 00 000 00 0 00000000 00000202 1 0
6 0 1 00000184 00000000 00000000 00000000 0d 341 0d 1 00000180 00000188 0 0
6 0 1 00000188 00000000 00000000 00000000 0e 342 0e 1 0000000b 0000018c 0 0
6 0 1 0000018c 00000000 00000000 00000000 0f 300 0f 1 00000000 00000190 0 0
6 0 1 00000190 00000080 00000000 00000000 10 300 10 1 00000000 00000194 0 0
8 0 0 00000194 00000000 00000000 00000000 00 000 00 0 00000000 00000180 0 0
6 0 1 00000198 00000000 00000000 00000000 11 300 11 1 00000088 0000019c 0 0
9 0 0 0000019c 00000000 00000000 00000000 00 000 00 0 00000000 000001a0 0 1

//--- vlog.f
source/exu_pkg.sv
source/exu_skid_buf.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_csr_file.sv
source/exu_lsu.sv
source/exu_core.sv
source/exu_top.sv
dv/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = exu_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
